/* project.f */
rtl/wh_test_pkg.sv
rtl/wh_data_gen.sv
rtl/wh_two_fifo.sv
rtl/wh_flit_serializer.sv
rtl/wh_flit_deserializer.sv
rtl/wh_test_node.sv
rtl/wh_test_loop_top.sv
verif/wh_test_checker.sv
verif/wh_test_tb.sv

/* rtl/wh_data_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Payload pattern generator, one packet per advance strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wh_data_gen (
  input  logic               node_clk_i,
  input  logic               node_reset_i,
  input  logic               advance_i,
  output wh_test_pkg::load_t load_o
);
  import wh_test_pkg::*;

  // Only the low bits of the index matter mod 256
  channel_t pkt_idx_q;

  always_ff @(posedge node_clk_i)
  begin
    if (node_reset_i)
      pkt_idx_q <= '0;
    else if (advance_i)
      pkt_idx_q <= pkt_idx_q + 1'b1;
  end

  // Channel k carries n*num_channels + k
  always_comb
  begin
    for (int k = 0; k < num_channels; k++)
    begin
      load_o[k*channel_width +: channel_width] = channel_t'(pkt_idx_q * num_channels + k);
    end
  end

endmodule

/* rtl/wh_flit_deserializer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flit to packet converter for the incoming link
// Valid rises the cycle after the last flit arrives
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wh_flit_deserializer (
  input  logic                    node_clk_i,
  input  logic                    node_reset_i,
  input  wh_test_pkg::wh_link_s   link_i,
  output logic                    ready_and_o,
  output logic                    valid_o,
  output wh_test_pkg::wh_packet_s packet_o,
  input  logic                    yumi_i
);
  import wh_test_pkg::*;

  wh_flits_t slots_q;
  flit_idx_t cnt_q;
  logic      full_q;
  logic      recv;
  logic      last_flit;

  // Link stays blocked while a whole packet waits to be taken
  assign ready_and_o = ~full_q | yumi_i;
  assign recv        = link_i.v & ready_and_o;
  assign last_flit   = (cnt_q == flit_idx_t'(wh_ratio - 1));

  assign valid_o  = full_q;
  assign packet_o = slots_q[wh_packet_width-1:0];

  always_ff @(posedge node_clk_i)
  begin
    if (recv)
      slots_q[cnt_q*flit_width +: flit_width] <= link_i.data;
  end

  always_ff @(posedge node_clk_i)
  begin
    if (node_reset_i)
    begin
      full_q <= 1'b0;
      cnt_q  <= '0;
    end
    else
    begin
      if (yumi_i)
        full_q <= 1'b0;
      if (recv && last_flit)
      begin
        cnt_q  <= '0;
        full_q <= 1'b1;
      end
      else if (recv)
        cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

/* rtl/wh_flit_serializer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet to flit converter for the outgoing link
// Sends the low flit first, wh_ratio flits per packet
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wh_flit_serializer (
  input  logic                    node_clk_i,
  input  logic                    node_reset_i,
  input  logic                    valid_i,
  input  wh_test_pkg::wh_packet_s packet_i,
  output logic                    ready_and_o,
  output wh_test_pkg::wh_link_s   link_o,
  input  wh_test_pkg::wh_link_s   link_i
);
  import wh_test_pkg::*;

  wh_flits_t shift_q;
  flit_idx_t cnt_q;
  logic      loaded_q;
  logic      last_flit;
  logic      send;
  logic      load;

  assign last_flit = (cnt_q == flit_idx_t'(wh_ratio - 1));
  assign send      = loaded_q & link_i.ready_and_rev;

  // Take a new packet when idle or as the last flit leaves
  assign ready_and_o = ~loaded_q | (last_flit & link_i.ready_and_rev);
  assign load        = valid_i & ready_and_o;

  assign link_o.v    = loaded_q;
  assign link_o.data = shift_q[flit_width-1:0];
  // Reverse ready is owned by the receive side of the node
  assign link_o.ready_and_rev = 1'b0;

  always_ff @(posedge node_clk_i)
  begin
    if (load)
      shift_q <= wh_flits_t'(packet_i);
    else if (send)
      shift_q <= shift_q >> flit_width;
  end

  always_ff @(posedge node_clk_i)
  begin
    if (node_reset_i)
    begin
      loaded_q <= 1'b0;
      cnt_q    <= '0;
    end
    else if (load)
    begin
      loaded_q <= 1'b1;
      cnt_q    <= '0;
    end
    else if (send)
    begin
      cnt_q <= cnt_q + 1'b1;
      if (last_flit)
        loaded_q <= 1'b0;
    end
  end

endmodule

/* rtl/wh_test_loop_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Master and client test nodes joined by a flit link loop
// Status outputs come from the master
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wh_test_loop_top (
  input  logic                node_clk_i,
  input  logic                node_reset_i,
  input  logic                node_en_i,
  input  wh_test_pkg::cord_t  master_cord_i,
  input  wh_test_pkg::cid_t   master_cid_i,
  input  wh_test_pkg::cord_t  client_cord_i,
  input  wh_test_pkg::cid_t   client_cid_i,
  input  wh_test_pkg::cord_t  client_reply_cord_i,
  output logic                error_o,
  output wh_test_pkg::count_t sent_o,
  output wh_test_pkg::count_t received_o
);
  import wh_test_pkg::*;

  wh_link_s master_to_client;
  wh_link_s client_to_master;

  wh_test_node #(.is_client(1'b0)) i_master (
    .node_clk_i  (node_clk_i),
    .node_reset_i(node_reset_i),
    .node_en_i   (node_en_i),
    .my_cord_i   (master_cord_i),
    .dest_cord_i (client_cord_i),
    .my_cid_i    (master_cid_i),
    .dest_cid_i  (client_cid_i),
    .link_i      (client_to_master),
    .link_o      (master_to_client),
    .error_o     (error_o),
    .sent_o      (sent_o),
    .received_o  (received_o)
  );

  // Client status outputs are constant zero
  wh_test_node #(.is_client(1'b1)) i_client (
    .node_clk_i  (node_clk_i),
    .node_reset_i(node_reset_i),
    .node_en_i   (node_en_i),
    .my_cord_i   (client_cord_i),
    .dest_cord_i (client_reply_cord_i),
    .my_cid_i    (client_cid_i),
    .dest_cid_i  (master_cid_i),
    .link_i      (master_to_client),
    .link_o      (client_to_master),
    .error_o     (),
    .sent_o      (),
    .received_o  ()
  );

endmodule

/* rtl/wh_test_node.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wormhole traffic test node, master or client by is_client
// Master generates and checks, client loops payloads back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wh_test_node #(
  parameter bit is_client = 1'b0
) (
  input  logic                  node_clk_i,
  input  logic                  node_reset_i,
  input  logic                  node_en_i,
  input  wh_test_pkg::cord_t    my_cord_i,
  input  wh_test_pkg::cord_t    dest_cord_i,
  input  wh_test_pkg::cid_t     my_cid_i,
  input  wh_test_pkg::cid_t     dest_cid_i,
  input  wh_test_pkg::wh_link_s link_i,
  output wh_test_pkg::wh_link_s link_o,
  output logic                  error_o,
  output wh_test_pkg::count_t   sent_o,
  output wh_test_pkg::count_t   received_o
);
  import wh_test_pkg::*;

  // Link side converters
  logic       deser_ready;
  logic       deser_valid;
  wh_packet_s deser_packet;
  logic       ser_valid;
  logic       ser_ready;
  wh_packet_s ser_packet;
  wh_link_s   ser_link;

  // Node side of the FIFOs
  logic       in_ready;
  logic       in_valid;
  wh_packet_s in_packet;
  logic       in_yumi;
  logic       out_valid;
  logic       out_ready;
  wh_packet_s out_packet;

  wh_flit_deserializer i_deser (
    .node_clk_i  (node_clk_i),
    .node_reset_i(node_reset_i),
    .link_i      (link_i),
    .ready_and_o (deser_ready),
    .valid_o     (deser_valid),
    .packet_o    (deser_packet),
    .yumi_i      (deser_valid & in_ready)
  );

  // Responses in the master, requests in the client
  wh_two_fifo i_in_fifo (
    .node_clk_i  (node_clk_i),
    .node_reset_i(node_reset_i),
    .valid_i     (deser_valid),
    .data_i      (deser_packet),
    .ready_o     (in_ready),
    .valid_o     (in_valid),
    .data_o      (in_packet),
    .yumi_i      (in_yumi)
  );

  wh_two_fifo i_out_fifo (
    .node_clk_i  (node_clk_i),
    .node_reset_i(node_reset_i),
    .valid_i     (out_valid),
    .data_i      (out_packet),
    .ready_o     (out_ready),
    .valid_o     (ser_valid),
    .data_o      (ser_packet),
    .yumi_i      (ser_valid & ser_ready)
  );

  wh_flit_serializer i_ser (
    .node_clk_i  (node_clk_i),
    .node_reset_i(node_reset_i),
    .valid_i     (ser_valid),
    .packet_i    (ser_packet),
    .ready_and_o (ser_ready),
    .link_o      (ser_link),
    .link_i      (link_i)
  );

  // Outgoing flits plus our ready for the incoming direction
  always_comb
  begin
    link_o               = ser_link;
    link_o.ready_and_rev = deser_ready;
  end

  if (!is_client)
  begin : g_master
    load_t  gen_load;
    load_t  check_load;
    logic   req_accept;
    logic   resp_bad;
    logic   error_q;
    count_t sent_q;
    count_t received_q;

    assign out_valid  = node_en_i;
    assign req_accept = out_valid & out_ready;

    assign out_packet.load          = gen_load;
    assign out_packet.src_cid       = my_cid_i;
    assign out_packet.cid           = dest_cid_i;
    assign out_packet.header.cord   = dest_cord_i;
    assign out_packet.header.len    = len_t'(wh_len_value);

    // Responses never wait
    assign in_yumi = in_valid;

    wh_data_gen i_gen_req (
      .node_clk_i  (node_clk_i),
      .node_reset_i(node_reset_i),
      .advance_i   (req_accept),
      .load_o      (gen_load)
    );

    // Second copy tracks the expected response order
    wh_data_gen i_gen_check (
      .node_clk_i  (node_clk_i),
      .node_reset_i(node_reset_i),
      .advance_i   (in_yumi),
      .load_o      (check_load)
    );

    assign resp_bad = in_valid & ((in_packet.load != check_load)
                                  | (in_packet.header.cord != my_cord_i)
                                  | (in_packet.cid != my_cid_i));

    always_ff @(posedge node_clk_i)
    begin
      if (node_reset_i)
      begin
        error_q    <= 1'b0;
        sent_q     <= '0;
        received_q <= '0;
      end
      else
      begin
        if (resp_bad)
          error_q <= 1'b1;
        if (req_accept)
          sent_q <= sent_q + 1'b1;
        if (in_yumi)
          received_q <= received_q + 1'b1;
      end
    end

    assign error_o    = error_q;
    assign sent_o     = sent_q;
    assign received_o = received_q;
  end
  else
  begin : g_client
    // Head request turns into a response addressed to its sender
    assign out_valid = in_valid;
    assign in_yumi   = in_valid & out_ready;

    assign out_packet.load        = in_packet.load;
    assign out_packet.src_cid     = my_cid_i;
    assign out_packet.cid         = in_packet.src_cid;
    assign out_packet.header.cord = dest_cord_i;
    assign out_packet.header.len  = len_t'(wh_len_value);

    assign error_o    = 1'b0;
    assign sent_o     = '0;
    assign received_o = '0;
  end

endmodule

/* rtl/wh_test_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, flit and packet types for the wormhole test loop
// Imported by every RTL block and by the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package wh_test_pkg;

  // Link and packet field widths
  localparam int flit_width    = 16;
  localparam int cord_width    = 5;
  localparam int len_width     = 3;
  localparam int cid_width     = 2;
  localparam int num_channels  = 2;
  localparam int channel_width = 8;

  typedef logic [flit_width-1:0]                   flit_t;
  typedef logic [cord_width-1:0]                   cord_t;
  typedef logic [len_width-1:0]                    len_t;
  typedef logic [cid_width-1:0]                    cid_t;
  typedef logic [channel_width-1:0]                channel_t;
  typedef logic [num_channels*channel_width-1:0]   load_t;
  typedef logic [31:0]                             count_t;

  // Cord sits in the low bits of the header flit
  typedef struct packed {
    len_t  len;
    cord_t cord;
  } wh_header_s;

  typedef struct packed {
    load_t      load;
    cid_t       src_cid;
    cid_t       cid;
    wh_header_s header;
  } wh_packet_s;

  // One direction of a link plus the ready for the opposite direction
  typedef struct packed {
    logic  v;
    flit_t data;
    logic  ready_and_rev;
  } wh_link_s;

  localparam int wh_packet_width = $bits(wh_packet_s);
  localparam int wh_ratio        = (wh_packet_width + flit_width - 1) / flit_width;
  localparam int wh_len_value    = wh_ratio - 1;

  // Flit index inside a packet, at least one bit
  localparam int flit_idx_width = (wh_ratio > 1) ? $clog2(wh_ratio) : 1;

  typedef logic [flit_idx_width-1:0]      flit_idx_t;
  typedef logic [wh_ratio*flit_width-1:0] wh_flits_t;

endpackage

/* rtl/wh_two_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry packet FIFO, ready/valid in and valid/yumi out
// Enqueue while full is allowed when the head leaves in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wh_two_fifo (
  input  logic                   node_clk_i,
  input  logic                   node_reset_i,
  input  logic                   valid_i,
  input  wh_test_pkg::wh_packet_s data_i,
  output logic                   ready_o,
  output logic                   valid_o,
  output wh_test_pkg::wh_packet_s data_o,
  input  logic                   yumi_i
);
  import wh_test_pkg::*;

  wh_packet_s mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic       full_q;
  logic       empty_q;
  logic       enq;

  assign ready_o = ~full_q | yumi_i;
  assign enq     = valid_i & ready_o;
  assign valid_o = ~empty_q;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge node_clk_i)
  begin
    if (enq)
      mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge node_clk_i)
  begin
    if (node_reset_i)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end
    else
    begin
      if (enq)
        wr_ptr_q <= ~wr_ptr_q;
      if (yumi_i)
        rd_ptr_q <= ~rd_ptr_q;
      // Occupancy only changes when exactly one side moves
      if (enq && !yumi_i)
      begin
        empty_q <= 1'b0;
        full_q  <= (~wr_ptr_q == rd_ptr_q);
      end
      else if (yumi_i && !enq)
      begin
        full_q  <= 1'b0;
        empty_q <= (~rd_ptr_q == wr_ptr_q);
      end
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the wormhole test loop simulation with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --assert --top-module wh_test_tb \
    -Mdir "$build_dir" -f project.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! "./$build_dir/Vwh_test_tb" > "$log_file" 2>&1; then
  cat "$log_file"
  echo "Simulation exited with an error status"
  exit 1
fi

cat "$log_file"

if grep -q "^TESTS PASSED$" "$log_file"; then
  exit 0
fi
echo "Pass message not found in $log_file"
exit 1

/* verif/wh_test_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Count and error flag assertions for the loop top level
// Bound into wh_test_loop_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wh_test_checker (
  input logic                node_clk_i,
  input logic                node_reset_i,
  input logic                error_i,
  input wh_test_pkg::count_t sent_i,
  input wh_test_pkg::count_t received_i
);

  // Every response belongs to an earlier request
  a_received_le_sent: assert property (
    @(posedge node_clk_i) disable iff (node_reset_i)
    received_i <= sent_i
  ) else $error("received count is above sent count");

  // At most one request per cycle
  a_sent_step: assert property (
    @(posedge node_clk_i) disable iff (node_reset_i)
    (sent_i == $past(sent_i)) || (sent_i == $past(sent_i) + 1'b1)
  ) else $error("sent count jumped by more than one");

  a_received_step: assert property (
    @(posedge node_clk_i) disable iff (node_reset_i)
    (received_i == $past(received_i)) || (received_i == $past(received_i) + 1'b1)
  ) else $error("received count jumped by more than one");

  // Sticky until reset
  a_error_sticky: assert property (
    @(posedge node_clk_i) disable iff (node_reset_i)
    !$fell(error_i)
  ) else $error("error flag dropped without reset");

endmodule

bind wh_test_loop_top wh_test_checker i_checker (
  .node_clk_i  (node_clk_i),
  .node_reset_i(node_reset_i),
  .error_i     (error_o),
  .sent_i      (sent_o),
  .received_i  (received_o)
);

/* verif/wh_test_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the wormhole test loop
// Runs packet bursts through master and client, checks counts and error flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wh_test_tb;
  import wh_test_pkg::*;

  localparam int num_bursts  = 6;
  localparam int pkt_bound   = 20;
  localparam int fixed_bound = 1000;
  localparam int idle_gap    = 20;

  localparam cord_t master_cord = 5'h03;
  localparam cid_t  master_cid  = 2'h1;
  localparam cord_t client_cord = 5'h0a;
  localparam cid_t  client_cid  = 2'h2;
  localparam cord_t bad_cord    = 5'h1c;

  logic   node_clk;
  logic   node_reset;
  logic   node_en;
  cord_t  reply_cord;
  logic   error;
  count_t sent;
  count_t received;

  int unsigned burst_len [num_bursts];
  int unsigned watchdog_cycles;
  int          check_cnt;
  int          fail_cnt;
  int          test_cnt;

  wh_test_loop_top i_dut (
    .node_clk_i         (node_clk),
    .node_reset_i       (node_reset),
    .node_en_i          (node_en),
    .master_cord_i      (master_cord),
    .master_cid_i       (master_cid),
    .client_cord_i      (client_cord),
    .client_cid_i       (client_cid),
    .client_reply_cord_i(reply_cord),
    .error_o            (error),
    .sent_o             (sent),
    .received_o         (received)
  );

  initial
  begin
    node_clk = 1'b0;
    forever #2 node_clk = ~node_clk;
  end

  // Armed once the burst lengths are known
  initial
  begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge node_clk);
    $display("Watchdog expired after %0d cycles, traffic did not drain", watchdog_cycles);
    $display("TESTS FAILED");
    $finish;
  end

  task automatic check_count(input string name, input count_t actual, input count_t expected);
    check_cnt++;
    if (actual !== expected)
    begin
      fail_cnt++;
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    check_cnt++;
    if (actual !== expected)
    begin
      fail_cnt++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic report_test(input string name, input int fails_before);
    test_cnt++;
    if (fail_cnt == fails_before)
      $display("Test %0d %s: ok", test_cnt, name);
    else
      $display("Test %0d %s: %0d check(s) failed", test_cnt, name, fail_cnt - fails_before);
  endtask

  // Ends on a falling edge so outputs can be sampled
  task automatic apply_reset();
    @(posedge node_clk);
    node_reset <= 1'b1;
    repeat (8) @(posedge node_clk);
    node_reset <= 1'b0;
    @(negedge node_clk);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge node_clk);
  endtask

  // Enable until at least len more requests are accepted
  task automatic run_burst(input int unsigned len, output count_t sent_end);
    count_t target;
    target = sent + count_t'(len);
    @(posedge node_clk);
    node_en <= 1'b1;
    @(negedge node_clk);
    while (sent < target)
      @(negedge node_clk);
    @(posedge node_clk);
    node_en <= 1'b0;
    // One more accept can land on the edge that drops the enable
    @(negedge node_clk);
    sent_end = sent;
  endtask

  task automatic wait_drain();
    while (received != sent)
      @(negedge node_clk);
  endtask

  task automatic test_reset_state();
    int fails_before;
    fails_before = fail_cnt;
    check_flag("error_o", error, 1'b0);
    check_count("sent_o", sent, '0);
    check_count("received_o", received, '0);
    report_test("reset state", fails_before);
  endtask

  task automatic test_single_burst();
    int     fails_before;
    count_t sent_start;
    count_t sent_end;
    count_t delta;
    fails_before = fail_cnt;
    sent_start = sent;
    run_burst(burst_len[0], sent_end);
    wait_drain();
    // Burst length plus at most the accept on the disabling edge
    delta = sent - sent_start;
    check_flag("sent_o burst length in range",
               (delta >= count_t'(burst_len[0])) && (delta <= count_t'(burst_len[0] + 1)),
               1'b1);
    check_count("received_o", received, sent_end);
    check_flag("error_o", error, 1'b0);
    report_test("single burst", fails_before);
  endtask

  task automatic test_gapped_bursts();
    int     fails_before;
    count_t sent_end;
    fails_before = fail_cnt;
    for (int b = 1; b <= 3; b++)
    begin
      run_burst(burst_len[b], sent_end);
      idle_cycles(idle_gap);
      check_count("sent_o while idle", sent, sent_end);
    end
    wait_drain();
    check_count("received_o", received, sent_end);
    check_flag("error_o", error, 1'b0);
    report_test("gapped bursts", fails_before);
  endtask

  task automatic test_bad_reply_cord();
    int     fails_before;
    count_t sent_end;
    fails_before = fail_cnt;
    @(posedge node_clk);
    reply_cord <= bad_cord;
    run_burst(burst_len[4], sent_end);
    wait_drain();
    check_flag("error_o after traffic", error, 1'b1);
    idle_cycles(idle_gap);
    // Sticky flag survives the idle period
    check_flag("error_o after enable drop", error, 1'b1);
    report_test("bad reply cord", fails_before);
  endtask

  task automatic test_reset_recovery();
    int     fails_before;
    count_t sent_end;
    fails_before = fail_cnt;
    @(posedge node_clk);
    reply_cord <= master_cord;
    apply_reset();
    check_flag("error_o after reset", error, 1'b0);
    check_count("sent_o after reset", sent, '0);
    check_count("received_o after reset", received, '0);
    run_burst(burst_len[5], sent_end);
    wait_drain();
    check_count("received_o", received, sent_end);
    check_flag("error_o", error, 1'b0);
    report_test("reset recovery", fails_before);
  endtask

  initial
  begin
    int unsigned total_len;
    node_reset = 1'b1;
    node_en    = 1'b0;
    reply_cord = master_cord;
    check_cnt  = 0;
    fail_cnt   = 0;
    test_cnt   = 0;
    total_len  = 0;
    void'($urandom(65337));
    for (int i = 0; i < num_bursts; i++)
    begin
      burst_len[i] = $urandom_range(24, 4);
      total_len += burst_len[i];
    end
    watchdog_cycles = total_len * pkt_bound + fixed_bound;

    apply_reset();
    test_reset_state();
    test_single_burst();
    test_gapped_bursts();
    test_bad_reply_cord();
    test_reset_recovery();

    $display("Tests run %0d, checks run %0d, checks failed %0d", test_cnt, check_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule
